/* filelist.f */
rtl/mold_pkg.sv
rtl/mold_axis_stage.sv
rtl/mold_header_decoder.sv
rtl/mold_session_tracker.sv
rtl/mold_msg_aligner.sv
rtl/mold_msg_out.sv
rtl/moldudp64_top.sv
tb/mold_checker.sv
tb/tb_moldudp64.sv

/* run.sh */
#!/bin/sh
# build and run the MoldUDP64 parser testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_moldudp64 -f filelist.f -o sim

./obj_dir/sim | tee sim.log

if grep -q "^Test passed$" sim.log; then
	echo "simulation passed"
	exit 0
fi
echo "simulation failed"
exit 1

/* tb/tb_moldudp64.sv */
/*
 * MoldUDP64 parser testbench
 * builds packets, predicts the message beats from the wire format and
 * streams the packets into the DUT with random tvalid gaps
 */
`timescale 1ns/100ps
module tb_moldudp64;
	import mold_pkg::*;

	logic                  clk;
	logic                  nreset;
	logic                  udp_axis_tvalid;
	logic [AXI_KEEP_W-1:0] udp_axis_tkeep;
	logic [AXI_DATA_W-1:0] udp_axis_tdata;
	logic                  udp_axis_tlast;
	logic                  udp_axis_tready;
	logic                  mold_msg_v;
	logic                  mold_msg_start;
	logic [ML_W-1:0]       mold_msg_len;
	logic [SEQ_NUM_W-1:0]  mold_msg_seq_num;
	logic [SID_W-1:0]      mold_msg_sid;
	logic [AXI_KEEP_W-1:0] mold_msg_mask;
	logic [AXI_DATA_W-1:0] mold_msg_data;

	logic [7:0] pkt[$];
	int         beats_planned;
	int         test_beats;
	int         tests_run;
	int         tests_failed;
	int         err_base;

	initial clk = 1'b0;
	always #5 clk = ~clk;

	moldudp64_top dut0 (
		.clk                (clk),
		.nreset             (nreset),
		.udp_axis_tvalid_i  (udp_axis_tvalid),
		.udp_axis_tkeep_i   (udp_axis_tkeep),
		.udp_axis_tdata_i   (udp_axis_tdata),
		.udp_axis_tlast_i   (udp_axis_tlast),
		.udp_axis_tready_o  (udp_axis_tready),
		.mold_msg_v_o       (mold_msg_v),
		.mold_msg_start_o   (mold_msg_start),
		.mold_msg_len_o     (mold_msg_len),
		.mold_msg_seq_num_o (mold_msg_seq_num),
		.mold_msg_sid_o     (mold_msg_sid),
		.mold_msg_mask_o    (mold_msg_mask),
		.mold_msg_data_o    (mold_msg_data)
	);

	mold_checker chk0 (
		.clk           (clk),
		.nreset        (nreset),
		.msg_v_i       (mold_msg_v),
		.msg_start_i   (mold_msg_start),
		.msg_len_i     (mold_msg_len),
		.msg_seq_num_i (mold_msg_seq_num),
		.msg_sid_i     (mold_msg_sid),
		.msg_mask_i    (mold_msg_mask),
		.msg_data_i    (mold_msg_data)
	);

	// expected beats of the packet in pkt, read straight from the wire bytes
	function automatic int model_packet();
		logic [SID_W-1:0]      sid;
		logic [SEQ_NUM_W-1:0]  seq;
		logic [ML_W-1:0]       cnt;
		logic [ML_W-1:0]       len;
		logic [AXI_DATA_W-1:0] data;
		logic [AXI_KEEP_W-1:0] mask;
		int                    pos;
		int                    left;
		int                    n;
		int                    beats;
		sid = '0;
		seq = '0;
		for (int i = 0; i < 10; i++) begin
			sid = {sid[SID_W-9:0], pkt[i]};
		end
		for (int i = 10; i < 18; i++) begin
			seq = {seq[SEQ_NUM_W-9:0], pkt[i]};
		end
		cnt = {pkt[18], pkt[19]};
		// end of session announces no messages
		if (cnt == 16'hffff) begin
			cnt = '0;
		end
		pos = 20;
		beats = 0;
		for (int m = 0; m < int'(cnt); m++) begin
			len = {pkt[pos], pkt[pos+1]};
			pos += 2;
			left = int'(len);
			// a zero length still gives one start beat
			do begin
				n = (left > 8) ? 8 : left;
				data = '0;
				mask = '0;
				for (int k = 0; k < n; k++) begin
					data[8*k +: 8] = pkt[pos+k];
					mask[k] = 1'b1;
				end
				chk0.expect_beat(left == int'(len), len, seq + SEQ_NUM_W'(m), sid, mask, data);
				pos += n;
				left -= n;
				beats++;
			end while (left > 0);
		end
		return beats;
	endfunction

	task automatic start_packet(input logic [SID_W-1:0] sid, input logic [SEQ_NUM_W-1:0] seq,
			input logic [ML_W-1:0] cnt);
		pkt.delete();
		for (int i = 9; i >= 0; i--) begin
			pkt.push_back(sid[8*i +: 8]);
		end
		for (int i = 7; i >= 0; i--) begin
			pkt.push_back(seq[8*i +: 8]);
		end
		pkt.push_back(cnt[15:8]);
		pkt.push_back(cnt[7:0]);
	endtask

	task automatic add_message(input int len);
		pkt.push_back(8'(len >> 8));
		pkt.push_back(8'(len));
		for (int i = 0; i < len; i++) begin
			pkt.push_back(8'($urandom));
		end
	endtask

	task automatic idle_gap();
		int n;
		n = ($urandom_range(3, 0) == 0) ? int'($urandom_range(3, 1)) : 0;
		udp_axis_tvalid = 1'b0;
		repeat (n) @(negedge clk);
	endtask

	// entered on a falling edge, tready is stable until the next rising edge
	task automatic send_beat(input logic [AXI_DATA_W-1:0] data,
			input logic [AXI_KEEP_W-1:0] keep, input logic last);
		logic accepted;
		accepted = 1'b0;
		udp_axis_tvalid = 1'b1;
		udp_axis_tdata  = data;
		udp_axis_tkeep  = keep;
		udp_axis_tlast  = last;
		while (!accepted) begin
			#1;
			accepted = udp_axis_tready;
			@(negedge clk);
		end
		udp_axis_tvalid = 1'b0;
	endtask

	task automatic send_packet();
		logic [AXI_DATA_W-1:0] data;
		logic [AXI_KEEP_W-1:0] keep;
		int                    nb;
		nb = (pkt.size() + 7) / 8;
		beats_planned += nb;
		for (int b = 0; b < nb; b++) begin
			data = '0;
			keep = '0;
			for (int k = 0; k < 8; k++) begin
				if (8*b + k < pkt.size()) begin
					data[8*k +: 8] = pkt[8*b + k];
					keep[k] = 1'b1;
				end
			end
			idle_gap();
			send_beat(data, keep, b == nb - 1);
		end
	endtask

	task automatic run_packet();
		test_beats += model_packet();
		send_packet();
	endtask

	task automatic end_test(input int num, input string name);
		int errs;
		int waited;
		waited = 0;
		// the last output beats trail the last input beat by a few dozen cycles
		while (chk0.pending() != 0 && waited < 200) begin
			@(negedge clk);
			waited++;
		end
		// room for a stray beat to show up
		repeat (20) @(negedge clk);
		// expected queue only moves on the falling edge
		@(posedge clk);
		chk0.report_leftover();
		errs = chk0.err_cnt - err_base;
		err_base = chk0.err_cnt;
		tests_run++;
		if (errs != 0) begin
			tests_failed++;
		end
		$display("test %0d %s: %0d beats expected, %0d errors, %s",
			num, name, test_beats, errs, (errs == 0) ? "ok" : "FAIL");
		test_beats = 0;
		@(negedge clk);
	endtask

	task automatic test_single();
		start_packet(80'h0123_4567_89ab_cdef_0011, 64'd1000, 16'd1);
		add_message(16);
		run_packet();
		end_test(1, "one 16-byte message");
	endtask

	task automatic test_short();
		int lens[14];
		// second length field straddles beats 2 and 3
		lens = '{1, 0, 1, 3, 8, 2, 0, 0, 13, 1, 6, 9, 7, 5};
		start_packet(80'h5345_5353_494f_4e30_3031, 64'h0000_0001_0000_0000, 16'd14);
		for (int i = 0; i < 14; i++) begin
			add_message(lens[i]);
		end
		run_packet();
		end_test(2, "short messages");
	endtask

	task automatic test_sessions();
		for (int p = 0; p < 3; p++) begin
			start_packet(80'ha5a5_0000_0000_0000_0000 + SID_W'(p), 64'hffff_ffff_ffff_fffe + 64'(p * 7),
				16'd4);
			for (int m = 0; m < 4; m++) begin
				add_message($urandom_range(20, 0));
			end
			run_packet();
		end
		end_test(3, "sessions and sequence numbers");
	endtask

	task automatic test_empty();
		start_packet(80'h4845_4152_5442_4541_5430, 64'd77, 16'd0);
		run_packet();
		start_packet(80'h454e_445f_5345_5353_494f, 64'd78, 16'hffff);
		run_packet();
		start_packet(80'h4e45_5854_5f53_4553_534e, 64'd500, 16'd3);
		add_message(11);
		add_message(0);
		add_message(4);
		run_packet();
		end_test(4, "heartbeat and end of session");
	endtask

	task automatic test_random();
		int cnt;
		for (int p = 0; p < 200; p++) begin
			cnt = $urandom_range(6, 0);
			if ($urandom_range(19, 0) == 0) begin
				start_packet({16'($urandom), $urandom, $urandom}, {$urandom, $urandom}, 16'hffff);
			end else begin
				start_packet({16'($urandom), $urandom, $urandom}, {$urandom, $urandom}, 16'(cnt));
				for (int m = 0; m < cnt; m++) begin
					add_message($urandom_range(40, 0));
				end
			end
			run_packet();
		end
		end_test(5, "random packets");
	endtask

	initial begin
		void'($urandom(20889));
		beats_planned   = 0;
		test_beats      = 0;
		tests_run       = 0;
		tests_failed    = 0;
		err_base        = 0;
		nreset          = 1'b0;
		udp_axis_tvalid = 1'b0;
		udp_axis_tkeep  = '0;
		udp_axis_tdata  = '0;
		udp_axis_tlast  = 1'b0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		nreset = 1'b1;
		@(negedge clk);
		test_single();
		test_short();
		test_sessions();
		test_empty();
		test_random();
		$display("tests run %0d, tests failed %0d, output beats checked %0d, errors %0d",
			tests_run, tests_failed, chk0.chk_cnt, chk0.err_cnt);
		if (chk0.err_cnt == 0 && tests_failed == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	// budget grows with every packet sent
	initial begin : watchdog
		int cycles;
		cycles = 0;
		while (cycles <= 1000 + 20 * beats_planned) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: run stopped after %0d cycles with %0d input beats sent",
			cycles, beats_planned);
		$display("Test failed");
		$finish;
	end

endmodule

/* tb/mold_checker.sv */
/*
 * MoldUDP64 output checker
 * holds the expected message beats and compares each DUT output beat
 */
`timescale 1ns/100ps
module mold_checker (
	input  logic                             clk,
	input  logic                             nreset,
	input  logic                             msg_v_i,
	input  logic                             msg_start_i,
	input  logic [mold_pkg::ML_W-1:0]        msg_len_i,
	input  logic [mold_pkg::SEQ_NUM_W-1:0]   msg_seq_num_i,
	input  logic [mold_pkg::SID_W-1:0]       msg_sid_i,
	input  logic [mold_pkg::AXI_KEEP_W-1:0]  msg_mask_i,
	input  logic [mold_pkg::AXI_DATA_W-1:0]  msg_data_i
);
	import mold_pkg::*;

	logic                  exp_start[$];
	logic [ML_W-1:0]       exp_len[$];
	logic [SEQ_NUM_W-1:0]  exp_seq[$];
	logic [SID_W-1:0]      exp_sid[$];
	logic [AXI_KEEP_W-1:0] exp_mask[$];
	logic [AXI_DATA_W-1:0] exp_data[$];
	int                    err_cnt;
	int                    chk_cnt;

	initial begin
		err_cnt = 0;
		chk_cnt = 0;
	end

	function void expect_beat(input logic start, input logic [ML_W-1:0] len,
			input logic [SEQ_NUM_W-1:0] seq, input logic [SID_W-1:0] sid,
			input logic [AXI_KEEP_W-1:0] mask, input logic [AXI_DATA_W-1:0] data);
		exp_start.push_back(start);
		exp_len.push_back(len);
		exp_seq.push_back(seq);
		exp_sid.push_back(sid);
		exp_mask.push_back(mask);
		exp_data.push_back(data);
	endfunction

	function int pending();
		return exp_data.size();
	endfunction

	function void compare_value(input string name, input logic [SID_W-1:0] got,
			input logic [SID_W-1:0] want);
		if (got !== want) begin
			$display("Mismatch %s: got %0h expected %0h at output beat %0d",
				name, got, want, chk_cnt);
			err_cnt++;
		end
	endfunction

	function void report_leftover();
		if (pending() != 0) begin
			$display("%0d expected output beats never came out of the DUT", pending());
			err_cnt++;
			exp_start.delete();
			exp_len.delete();
			exp_seq.delete();
			exp_sid.delete();
			exp_mask.delete();
			exp_data.delete();
		end
	endfunction

	// outputs move on the rising edge, look at them half a cycle later
	always @(negedge clk) begin
		if (nreset && msg_v_i) begin
			if (pending() == 0) begin
				$display("output beat %0d came out while no beat was expected", chk_cnt);
				err_cnt++;
			end else begin
				compare_value("mold_msg_start_o", SID_W'(msg_start_i), SID_W'(exp_start[0]));
				// length only travels with the start beat
				if (exp_start[0]) begin
					compare_value("mold_msg_len_o", SID_W'(msg_len_i), SID_W'(exp_len[0]));
				end
				compare_value("mold_msg_seq_num_o", SID_W'(msg_seq_num_i), SID_W'(exp_seq[0]));
				compare_value("mold_msg_sid_o", msg_sid_i, exp_sid[0]);
				compare_value("mold_msg_mask_o", SID_W'(msg_mask_i), SID_W'(exp_mask[0]));
				compare_value("mold_msg_data_o", SID_W'(msg_data_i), SID_W'(exp_data[0]));
				void'(exp_start.pop_front());
				void'(exp_len.pop_front());
				void'(exp_seq.pop_front());
				void'(exp_sid.pop_front());
				void'(exp_mask.pop_front());
				void'(exp_data.pop_front());
			end
			chk_cnt++;
		end
	end

endmodule

/* rtl/moldudp64_top.sv */
/*
 * MoldUDP64 parser top level
 * AXI stream of UDP payload in, realigned mold messages out
 */
`timescale 1ns/100ps
module moldudp64_top (
	input  logic                             clk,
	input  logic                             nreset,
	input  logic                             udp_axis_tvalid_i,
	input  logic [mold_pkg::AXI_KEEP_W-1:0]  udp_axis_tkeep_i,
	input  logic [mold_pkg::AXI_DATA_W-1:0]  udp_axis_tdata_i,
	input  logic                             udp_axis_tlast_i,
	output logic                             udp_axis_tready_o,
	output logic                             mold_msg_v_o,
	output logic                             mold_msg_start_o,
	output logic [mold_pkg::ML_W-1:0]        mold_msg_len_o,
	output logic [mold_pkg::SEQ_NUM_W-1:0]   mold_msg_seq_num_o,
	output logic [mold_pkg::SID_W-1:0]       mold_msg_sid_o,
	output logic [mold_pkg::AXI_KEEP_W-1:0]  mold_msg_mask_o,
	output logic [mold_pkg::AXI_DATA_W-1:0]  mold_msg_data_o
);
	import mold_pkg::*;

	logic                  take;
	logic                  beat_v;
	mold_beat_u            beat_data;
	logic [KEEP_CNT_W-1:0] beat_cnt;
	logic                  beat_last;
	logic                  first_beat;
	logic [AXI_KEEP_W-1:0] lane_mask;
	logic                  hdr_done;
	logic [SID_W-1:0]      hdr_sid;
	logic [SEQ_NUM_W-1:0]  hdr_seq_num;
	logic [ML_W-1:0]       hdr_msg_cnt;
	logic [SEQ_NUM_W-1:0]  cur_seq_num;
	logic                  msgs_none;
	logic                  emit;
	logic                  start;
	logic [ML_W-1:0]       len;
	logic [KEEP_CNT_W-1:0] emit_cnt;
	logic [AXI_DATA_W-1:0] chunk_data;
	logic                  msg_end;

	mold_axis_stage m_stage (
		.clk           (clk),
		.nreset        (nreset),
		.axis_tvalid_i (udp_axis_tvalid_i),
		.axis_tkeep_i  (udp_axis_tkeep_i),
		.axis_tdata_i  (udp_axis_tdata_i),
		.axis_tlast_i  (udp_axis_tlast_i),
		.take_i        (take),
		.axis_tready_o (udp_axis_tready_o),
		.beat_v_o      (beat_v),
		.beat_data_o   (beat_data),
		.beat_cnt_o    (beat_cnt),
		.beat_last_o   (beat_last)
	);

	mold_header_decoder m_hdr (
		.clk          (clk),
		.nreset       (nreset),
		.beat_v_i     (beat_v),
		.beat_data_i  (beat_data),
		.beat_last_i  (beat_last),
		.take_i       (take),
		.first_beat_o (first_beat),
		.lane_mask_o  (lane_mask),
		.hdr_done_o   (hdr_done),
		.sid_o        (hdr_sid),
		.seq_num_o    (hdr_seq_num),
		.msg_cnt_o    (hdr_msg_cnt)
	);

	mold_session_tracker m_session (
		.clk         (clk),
		.nreset      (nreset),
		.hdr_done_i  (hdr_done),
		.seq_num_i   (hdr_seq_num),
		.msg_cnt_i   (hdr_msg_cnt),
		.msg_end_i   (msg_end),
		.seq_num_o   (cur_seq_num),
		.msgs_none_o (msgs_none)
	);

	mold_msg_aligner m_align (
		.clk          (clk),
		.nreset       (nreset),
		.beat_v_i     (beat_v),
		.beat_data_i  (beat_data),
		.beat_cnt_i   (beat_cnt),
		.beat_last_i  (beat_last),
		.first_beat_i (first_beat),
		.lane_mask_i  (lane_mask),
		.msgs_none_i  (msgs_none),
		.take_o       (take),
		.emit_o       (emit),
		.start_o      (start),
		.len_o        (len),
		.emit_cnt_o   (emit_cnt),
		.data_o       (chunk_data),
		.msg_end_o    (msg_end)
	);

	mold_msg_out m_out (
		.clk                (clk),
		.nreset             (nreset),
		.emit_i             (emit),
		.start_i            (start),
		.len_i              (len),
		.emit_cnt_i         (emit_cnt),
		.data_i             (chunk_data),
		.seq_num_i          (cur_seq_num),
		.sid_i              (hdr_sid),
		.mold_msg_v_o       (mold_msg_v_o),
		.mold_msg_start_o   (mold_msg_start_o),
		.mold_msg_len_o     (mold_msg_len_o),
		.mold_msg_seq_num_o (mold_msg_seq_num_o),
		.mold_msg_sid_o     (mold_msg_sid_o),
		.mold_msg_mask_o    (mold_msg_mask_o),
		.mold_msg_data_o    (mold_msg_data_o)
	);

endmodule

/* rtl/mold_msg_out.sv */
/*
 * MoldUDP64 message output register
 * one output beat per emit, thermometer byte mask, unused lanes zeroed
 */
`timescale 1ns/100ps
module mold_msg_out (
	input  logic                             clk,
	input  logic                             nreset,
	input  logic                             emit_i,
	input  logic                             start_i,
	input  logic [mold_pkg::ML_W-1:0]        len_i,
	input  logic [mold_pkg::KEEP_CNT_W-1:0]  emit_cnt_i,
	input  logic [mold_pkg::AXI_DATA_W-1:0]  data_i,
	input  logic [mold_pkg::SEQ_NUM_W-1:0]   seq_num_i,
	input  logic [mold_pkg::SID_W-1:0]       sid_i,
	output logic                             mold_msg_v_o,
	output logic                             mold_msg_start_o,
	output logic [mold_pkg::ML_W-1:0]        mold_msg_len_o,
	output logic [mold_pkg::SEQ_NUM_W-1:0]   mold_msg_seq_num_o,
	output logic [mold_pkg::SID_W-1:0]       mold_msg_sid_o,
	output logic [mold_pkg::AXI_KEEP_W-1:0]  mold_msg_mask_o,
	output logic [mold_pkg::AXI_DATA_W-1:0]  mold_msg_data_o
);
	import mold_pkg::*;

	logic [AXI_KEEP_W-1:0] mask;
	logic [AXI_DATA_W-1:0] data_masked;

	always_comb begin
		for (int i = 0; i < AXI_KEEP_W; i++) begin
			mask[i]              = (emit_cnt_i > KEEP_CNT_W'(i));
			data_masked[8*i +: 8] = mask[i] ? data_i[8*i +: 8] : 8'h00;
		end
	end

	always @(posedge clk) begin
		if (~nreset) begin
			mold_msg_v_o     <= 1'b0;
			mold_msg_start_o <= 1'b0;
		end else begin
			mold_msg_v_o     <= emit_i;
			mold_msg_start_o <= emit_i & start_i;
		end
	end

	always @(posedge clk) begin
		if (emit_i) begin
			mold_msg_len_o     <= len_i;
			mold_msg_seq_num_o <= seq_num_i;
			mold_msg_sid_o     <= sid_i;
			mold_msg_mask_o    <= mask;
			mold_msg_data_o    <= data_masked;
		end
	end

endmodule

/* rtl/mold_msg_aligner.sv */
/*
 * MoldUDP64 message aligner
 * packs payload bytes into a residual buffer, parses the length fields
 * and cuts every message into chunks that start at lane 0
 */
`timescale 1ns/100ps
module mold_msg_aligner (
	input  logic                             clk,
	input  logic                             nreset,
	input  logic                             beat_v_i,
	input  mold_pkg::mold_beat_u             beat_data_i,
	input  logic [mold_pkg::KEEP_CNT_W-1:0]  beat_cnt_i,
	input  logic                             beat_last_i,
	input  logic                             first_beat_i,
	input  logic [mold_pkg::AXI_KEEP_W-1:0]  lane_mask_i,
	input  logic                             msgs_none_i,
	output logic                             take_o,
	output logic                             emit_o,
	output logic                             start_o,
	output logic [mold_pkg::ML_W-1:0]        len_o,
	output logic [mold_pkg::KEEP_CNT_W-1:0]  emit_cnt_o,
	output logic [mold_pkg::AXI_DATA_W-1:0]  data_o,
	output logic                             msg_end_o
);
	import mold_pkg::*;

	logic [BUF_BYTES-1:0][7:0]   buf_q;
	logic [BUF_BYTES-1:0][7:0]   buf_shift;
	logic [BUF_BYTES-1:0][7:0]   buf_next;
	logic [BUF_BYTES*8-1:0]      buf_keep;
	logic [BUF_BYTES*8-1:0]      buf_ins;
	logic [KEEP_CNT_W:0]         fill_q;
	logic [KEEP_CNT_W:0]         fill_base;
	logic [KEEP_CNT_W:0]         fill_next;
	logic                        pay_q;
	logic                        first_q;
	logic                        pkt_end_q;
	logic [ML_W-1:0]             rem_q;
	logic [ML_W-1:0]             len_q;
	logic                        clear;
	logic                        parse;
	logic                        zero_len;
	logic [ML_W-1:0]             parse_len;
	logic                        chunk;
	logic                        last_chunk;
	logic [KEEP_CNT_W-1:0]       chunk_n;
	logic [KEEP_CNT_W-1:0]       pop_n;
	logic [KEEP_CNT_W-1:0]       lo;
	logic [KEEP_CNT_W-1:0]       app_n;
	logic                        app_en;
	logic [AXI_DATA_W-1:0]       app_keep;
	logic [AXI_DATA_W-1:0]       app_word;

	// trailing bytes of a finished packet are dropped
	assign clear = pkt_end_q & msgs_none_i;

	// next packet waits for the previous one to drain completely
	assign take_o = beat_v_i & (fill_q <= (KEEP_CNT_W+1)'(AXI_KEEP_W))
		& (~first_beat_i | (msgs_none_i & (fill_q == '0)));

	// length phase
	assign parse_len = {buf_q[0], buf_q[1]};
	assign parse     = ~pay_q & ~msgs_none_i & (fill_q >= (KEEP_CNT_W+1)'(2));
	assign zero_len  = (parse_len == '0);

	// payload phase
	assign last_chunk = (rem_q <= ML_W'(AXI_KEEP_W));
	assign chunk_n    = last_chunk ? rem_q[KEEP_CNT_W-1:0] : KEEP_CNT_W'(AXI_KEEP_W);
	assign chunk      = pay_q & (fill_q >= {1'b0, chunk_n});

	assign pop_n = parse ? KEEP_CNT_W'(2) : (chunk ? chunk_n : '0);

	// header lanes sit below the payload lanes
	always_comb begin
		lo = '0;
		for (int i = 0; i < AXI_KEEP_W; i++) begin
			if (!lane_mask_i[i]) begin
				lo = lo + KEEP_CNT_W'(1);
			end
		end
	end

	// beat 2 lands before the tracker has the new count
	assign app_en   = take_o & (~msgs_none_i | ~lane_mask_i[0]);
	assign app_n    = (app_en && beat_cnt_i > lo) ? beat_cnt_i - lo : '0;
	assign app_keep = ~({AXI_DATA_W{1'b1}} << {app_n, 3'b000});
	assign app_word = (beat_data_i.lane >> {lo, 3'b000}) & app_keep;

	// pop from the bottom, append right above what is left
	assign fill_base = fill_q - {1'b0, pop_n};
	assign buf_shift = buf_q >> {pop_n, 3'b000};
	assign buf_keep  = ~({BUF_BYTES*8{1'b1}} << {fill_base, 3'b000});
	assign buf_ins   = {{(BUF_BYTES-AXI_KEEP_W)*8{1'b0}}, app_word} << {fill_base, 3'b000};
	assign buf_next  = (buf_shift & buf_keep) | buf_ins;
	assign fill_next = clear ? '0 : fill_base + {1'b0, app_n};

	always @(posedge clk) begin
		if (~nreset) begin
			fill_q    <= '0;
			pay_q     <= 1'b0;
			first_q   <= 1'b0;
			pkt_end_q <= 1'b0;
		end else begin
			fill_q <= fill_next;
			if (parse && !zero_len) begin
				pay_q   <= 1'b1;
				first_q <= 1'b1;
			end else if (chunk) begin
				first_q <= 1'b0;
				if (last_chunk) begin
					pay_q <= 1'b0;
				end
			end
			if (take_o && beat_last_i) begin
				pkt_end_q <= 1'b1;
			end else if (take_o && first_beat_i) begin
				pkt_end_q <= 1'b0;
			end
		end
	end

	always @(posedge clk) begin
		buf_q <= buf_next;
		if (parse) begin
			len_q <= parse_len;
			rem_q <= parse_len;
		end else if (chunk) begin
			rem_q <= rem_q - ML_W'(chunk_n);
		end
	end

	// an empty message goes out in the cycle its length is parsed
	assign emit_o     = chunk | (parse & zero_len);
	assign start_o    = parse | first_q;
	assign len_o      = parse ? parse_len : len_q;
	assign emit_cnt_o = parse ? '0 : chunk_n;
	assign data_o     = buf_q[AXI_KEEP_W-1:0];
	assign msg_end_o  = (parse & zero_len) | (chunk & last_chunk);

	a_fill_bound : assert property (@(posedge clk) disable iff (~nreset)
		fill_q <= (KEEP_CNT_W+1)'(BUF_BYTES));

endmodule

/* rtl/mold_session_tracker.sv */
/*
 * MoldUDP64 session tracker
 * current sequence number and count of messages still to come
 */
`timescale 1ns/100ps
module mold_session_tracker (
	input  logic                             clk,
	input  logic                             nreset,
	input  logic                             hdr_done_i,
	input  logic [mold_pkg::SEQ_NUM_W-1:0]   seq_num_i,
	input  logic [mold_pkg::ML_W-1:0]        msg_cnt_i,
	input  logic                             msg_end_i,
	output logic [mold_pkg::SEQ_NUM_W-1:0]   seq_num_o,
	output logic                             msgs_none_o
);
	import mold_pkg::*;

	logic [SEQ_NUM_W-1:0] seq_q;
	logic [ML_W-1:0]      cnt_q;

	// end of session count carries no messages
	always @(posedge clk) begin
		if (~nreset) begin
			cnt_q <= '0;
		end else if (hdr_done_i) begin
			cnt_q <= (msg_cnt_i == '1) ? '0 : msg_cnt_i;
		end else if (msg_end_i) begin
			cnt_q <= cnt_q - ML_W'(1);
		end
	end

	always @(posedge clk) begin
		if (hdr_done_i) begin
			seq_q <= seq_num_i;
		end else if (msg_end_i) begin
			seq_q <= seq_q + SEQ_NUM_W'(1);
		end
	end

	assign seq_num_o   = seq_q;
	assign msgs_none_o = (cnt_q == '0);

	// aligner only closes messages the header announced
	a_end_with_msgs : assert property (@(posedge clk) disable iff (~nreset)
		msg_end_i |-> ~msgs_none_o);

endmodule

/* rtl/mold_header_decoder.sv */
/*
 * MoldUDP64 header decoder
 * tracks the beat position in a packet, pulls session id and sequence
 * number out of the header and marks which lanes carry message bytes
 */
`timescale 1ns/100ps
module mold_header_decoder (
	input  logic                             clk,
	input  logic                             nreset,
	input  logic                             beat_v_i,
	input  mold_pkg::mold_beat_u             beat_data_i,
	input  logic                             beat_last_i,
	input  logic                             take_i,
	output logic                             first_beat_o,
	output logic [mold_pkg::AXI_KEEP_W-1:0]  lane_mask_o,
	output logic                             hdr_done_o,
	output logic [mold_pkg::SID_W-1:0]       sid_o,
	output logic [mold_pkg::SEQ_NUM_W-1:0]   seq_num_o,
	output logic [mold_pkg::ML_W-1:0]        msg_cnt_o
);
	import mold_pkg::*;

	logic [1:0]              idx_q;
	logic                    take_beat;
	logic [SID_W-1:0]        sid_q;
	logic [SEQ_NUM_W-17:0]   seq_hi_q;

	assign take_beat = beat_v_i & take_i;

	// saturates once past the header, restarts after tlast
	always @(posedge clk) begin
		if (~nreset) begin
			idx_q <= 2'd0;
		end else if (take_beat) begin
			if (beat_last_i) begin
				idx_q <= 2'd0;
			end else if (idx_q != 2'(HDR_BEATS)) begin
				idx_q <= idx_q + 2'd1;
			end
		end
	end

	// header fields are big endian, wire byte 0 is the msb
	always @(posedge clk) begin
		if (take_beat && idx_q == 2'd0) begin
			sid_q[SID_W-1 -: AXI_DATA_W] <= {<<8{beat_data_i.lane}};
		end
		if (take_beat && idx_q == 2'd1) begin
			sid_q[15:0] <= {beat_data_i.lane[0], beat_data_i.lane[1]};
			seq_hi_q    <= {<<8{beat_data_i.lane[AXI_KEEP_W-1:2]}};
		end
	end

	always_comb begin
		case (idx_q)
			2'd0, 2'd1:       lane_mask_o = '0;
			2'(HDR_BEATS-1):  lane_mask_o = {{(AXI_KEEP_W-HDR_TAIL_LANES){1'b1}},
			                                {HDR_TAIL_LANES{1'b0}}};
			default:          lane_mask_o = '1;
		endcase
	end

	assign first_beat_o = (idx_q == 2'd0);
	assign hdr_done_o   = take_beat & (idx_q == 2'(HDR_BEATS-1));
	assign sid_o        = sid_q;

	// low sequence bytes and count come with the beat-2 take, tracker loads them
	assign seq_num_o = {seq_hi_q, beat_data_i.tail.seq_lo[0], beat_data_i.tail.seq_lo[1]};
	assign msg_cnt_o = {beat_data_i.tail.cnt[0], beat_data_i.tail.cnt[1]};

	a_no_short_pkt : assert property (@(posedge clk) disable iff (~nreset)
		(take_beat && beat_last_i) |-> (idx_q >= 2'(HDR_BEATS-1)));

endmodule

/* rtl/mold_axis_stage.sv */
/*
 * Input stage of the MoldUDP64 parser
 * one-entry register on the AXI stream, tready while empty or draining
 */
`timescale 1ns/100ps
module mold_axis_stage (
	input  logic                              clk,
	input  logic                              nreset,
	input  logic                              axis_tvalid_i,
	input  logic [mold_pkg::AXI_KEEP_W-1:0]   axis_tkeep_i,
	input  logic [mold_pkg::AXI_DATA_W-1:0]   axis_tdata_i,
	input  logic                              axis_tlast_i,
	input  logic                              take_i,
	output logic                              axis_tready_o,
	output logic                              beat_v_o,
	output mold_pkg::mold_beat_u              beat_data_o,
	output logic [mold_pkg::KEEP_CNT_W-1:0]   beat_cnt_o,
	output logic                              beat_last_o
);
	import mold_pkg::*;

	logic                  full_q;
	logic                  xfer;
	logic [KEEP_CNT_W-1:0] keep_cnt;

	assign axis_tready_o = ~full_q | take_i;
	assign xfer          = axis_tvalid_i & axis_tready_o;

	// byte count of the incoming beat
	always_comb begin
		keep_cnt = '0;
		for (int i = 0; i < AXI_KEEP_W; i++) begin
			keep_cnt = keep_cnt + KEEP_CNT_W'(axis_tkeep_i[i]);
		end
	end

	always @(posedge clk) begin
		if (~nreset) begin
			full_q <= 1'b0;
		end else if (xfer) begin
			full_q <= 1'b1;
		end else if (take_i) begin
			full_q <= 1'b0;
		end
	end

	always @(posedge clk) begin
		if (xfer) begin
			beat_data_o <= axis_tdata_i;
			beat_cnt_o  <= keep_cnt;
			beat_last_o <= axis_tlast_i;
		end
	end

	assign beat_v_o = full_q;

	// tkeep fills from lane 0 and is only partial on the last beat
	a_tkeep_shape : assert property (@(posedge clk) disable iff (~nreset)
		axis_tvalid_i |-> axis_tkeep_i[0]
			&& (((axis_tkeep_i + AXI_KEEP_W'(1)) & axis_tkeep_i) == '0)
			&& (axis_tlast_i || (&axis_tkeep_i)));

endmodule

/* rtl/mold_pkg.sv */
/*
 * MoldUDP64 parser shared definitions
 * stream widths, header geometry and the two views of one stream beat
 */
package mold_pkg;

	// stream side
	localparam int AXI_DATA_W = 64;
	localparam int AXI_KEEP_W = 8;
	localparam int KEEP_CNT_W = 4;

	// moldudp64 header fields
	localparam int SID_W      = 80;
	localparam int SEQ_NUM_W  = 64;
	localparam int ML_W       = 16;

	// header spans 20 bytes, so beats 0..2
	localparam int HDR_BEATS      = 3;
	localparam int HDR_TAIL_LANES = 4;

	// two beats worth of realignment storage
	localparam int BUF_BYTES = 16;

	// beat 2 carries the end of the header and the start of the messages
	typedef union packed {
		logic [AXI_KEEP_W-1:0][7:0] lane;
		struct packed {
			logic [AXI_KEEP_W-HDR_TAIL_LANES-1:0][7:0] msg_head;
			logic [1:0][7:0]                           cnt;
			logic [1:0][7:0]                           seq_lo;
		} tail;
	} mold_beat_u;

endpackage
